// File: src/fft16_pkg.sv
package fft16_pkg;

    localparam int N_POINTS = 16;
    localparam int N_STAGES = 4;
    localparam int N_BFLY   = 8;

    typedef logic signed [15:0] sample_t;

    // sample in 23:8, 8 guard bits above, 8 fraction bits below
    typedef logic signed [31:0] word_t;

    typedef struct packed {
        word_t re;
        word_t im;
    } cplx_t;

    typedef word_t [N_POINTS-1:0] frame_t;

    typedef struct packed {
        sample_t [N_POINTS-1:0] re;
        sample_t [N_POINTS-1:0] im;
    } spectrum_t;

    ////////////////////////////////////////////////////////////
    // Q16 twiddles, W16^n for n = 0..7
    ////////////////////////////////////////////////////////////
    localparam word_t TW_RE [N_BFLY] = '{
        32'sh00010000, 32'sh0000EC83, 32'sh0000B504, 32'sh000061F7,
        32'sh00000000, 32'shFFFF9E09, 32'shFFFF4AFC, 32'shFFFF137D
    };

    localparam word_t TW_IM [N_BFLY] = '{
        32'sh00000000, 32'shFFFF9E09, 32'shFFFF4AFC, 32'shFFFF137D,
        32'shFFFF0000, 32'shFFFF137D, 32'shFFFF4AFC, 32'shFFFF9E09
    };

    ////////////////////////////////////////////////////////////
    // DIF index rules, stage 1..N_STAGES
    ////////////////////////////////////////////////////////////
    function automatic int stage_span(input logic [2:0] stage);
        return (N_POINTS / 2) >> (int'(stage) - 1);
    endfunction

    function automatic logic [3:0] stage_pair_a(input logic [2:0] stage,
                                                input logic [2:0] bfly);
        int span;
        int lo;
        span = stage_span(stage);
        lo   = (int'(bfly) / span) * 2 * span + int'(bfly) % span;
        return 4'(lo);
    endfunction

    function automatic logic [3:0] stage_pair_b(input logic [2:0] stage,
                                                input logic [2:0] bfly);
        return stage_pair_a(stage, bfly) + 4'(stage_span(stage));
    endfunction

    function automatic logic [2:0] stage_twiddle(input logic [2:0] stage,
                                                 input logic [2:0] bfly);
        int lo;
        lo = int'(stage_pair_a(stage, bfly));
        return 3'((lo % stage_span(stage)) << (int'(stage) - 1));
    endfunction

endpackage

// File: src/sample_collector.sv
module sample_collector
    import fft16_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  sample_t fir_d,
    input  logic    fir_valid,
    output frame_t  frame,
    output logic    frame_ready
);

    logic [3:0] wr_cnt;

    // slot counter and full strobe
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_cnt      <= '0;
            frame_ready <= 1'b0;
        end else if (fir_valid) begin
            wr_cnt      <= wr_cnt + 4'd1;
            frame_ready <= (wr_cnt == 4'(N_POINTS - 1));
        end else begin
            frame_ready <= 1'b0;
        end
    end

    // sign extend into the guard bits, fraction starts at zero
    always_ff @(posedge clk) begin
        if (fir_valid) begin
            frame[wr_cnt] <= {{8{fir_d[15]}}, fir_d, 8'h00};
        end
    end

endmodule

// File: src/butterfly.sv
module butterfly
    import fft16_pkg::*;
(
    input  cplx_t a,
    input  cplx_t b,
    input  word_t w_re,
    input  word_t w_im,
    output cplx_t sum,
    output cplx_t diff
);

    word_t             d_re;
    word_t             d_im;
    logic signed [63:0] p_rr;
    logic signed [63:0] p_ii;
    logic signed [63:0] p_ri;
    logic signed [63:0] p_ir;

    assign d_re = a.re - b.re;
    assign d_im = a.im - b.im;

    // negate before the multiply so truncation matches bit for bit
    assign p_rr = d_re * w_re;
    assign p_ii = -d_im * w_im;
    assign p_ri = d_re * w_im;
    assign p_ir = d_im * w_re;

    assign sum.re  = a.re + b.re;
    assign sum.im  = a.im + b.im;
    assign diff.re = p_rr[47:16] + p_ii[47:16];
    assign diff.im = p_ri[47:16] + p_ir[47:16];

endmodule

// File: src/fft_stage_engine.sv
module fft_stage_engine
    import fft16_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  frame_t               frame,
    input  logic                 frame_ready,
    output cplx_t [N_POINTS-1:0] result,
    output logic                 result_ready
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_STAGE1,
        S_STAGE2,
        S_STAGE3,
        S_STAGE4,
        S_FINISH
    } state_t;

    state_t               state;
    state_t               state_nxt;
    logic [2:0]           stage_num;
    logic                 rd_b;
    cplx_t [N_POINTS-1:0] buf_a;
    cplx_t [N_POINTS-1:0] buf_b;
    cplx_t [N_POINTS-1:0] src;
    logic [3:0]           idx_a  [N_BFLY];
    logic [3:0]           idx_b  [N_BFLY];
    logic [2:0]           tw_idx [N_BFLY];
    cplx_t                bf_sum [N_BFLY];
    cplx_t                bf_diff[N_BFLY];

    ////////////////////////////////////////////////////////////
    // sequencer
    ////////////////////////////////////////////////////////////
    always_comb begin
        unique case (state)
            S_IDLE:   state_nxt = frame_ready ? S_STAGE1 : S_IDLE;
            S_STAGE1: state_nxt = S_STAGE2;
            S_STAGE2: state_nxt = S_STAGE3;
            S_STAGE3: state_nxt = S_STAGE4;
            S_STAGE4: state_nxt = S_FINISH;
            default:  state_nxt = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= S_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // idle and finish fall back to stage 1 indices, nothing is written then
    always_comb begin
        unique case (state)
            S_STAGE2: stage_num = 3'd2;
            S_STAGE3: stage_num = 3'd3;
            S_STAGE4: stage_num = 3'd4;
            default:  stage_num = 3'd1;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // butterfly array
    ////////////////////////////////////////////////////////////
    // odd stages read a, even stages read b
    assign rd_b = (state == S_STAGE2) || (state == S_STAGE4);
    assign src  = rd_b ? buf_b : buf_a;

    always_comb begin
        for (int k = 0; k < N_BFLY; k++) begin
            idx_a[k]  = stage_pair_a(stage_num, 3'(k));
            idx_b[k]  = stage_pair_b(stage_num, 3'(k));
            tw_idx[k] = stage_twiddle(stage_num, 3'(k));
        end
    end

    for (genvar k = 0; k < N_BFLY; k++) begin : g_bf
        butterfly u_bf (
            .a    (src[idx_a[k]]),
            .b    (src[idx_b[k]]),
            .w_re (TW_RE[tw_idx[k]]),
            .w_im (TW_IM[tw_idx[k]]),
            .sum  (bf_sum[k]),
            .diff (bf_diff[k])
        );
    end

    ////////////////////////////////////////////////////////////
    // ping-pong writeback
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        unique case (state)
            S_IDLE: begin
                if (frame_ready) begin
                    for (int i = 0; i < N_POINTS; i++) begin
                        buf_a[i] <= '{re: frame[i], im: '0};
                    end
                end
            end
            S_STAGE1, S_STAGE3: begin
                for (int k = 0; k < N_BFLY; k++) begin
                    buf_b[idx_a[k]] <= bf_sum[k];
                    buf_b[idx_b[k]] <= bf_diff[k];
                end
            end
            S_STAGE2, S_STAGE4: begin
                for (int k = 0; k < N_BFLY; k++) begin
                    buf_a[idx_a[k]] <= bf_sum[k];
                    buf_a[idx_b[k]] <= bf_diff[k];
                end
            end
            default: ;
        endcase
    end

    // stage 4 lands in a, bins still bit reversed
    assign result       = buf_a;
    assign result_ready = (state == S_FINISH);

endmodule

// File: src/spectrum_output.sv
module spectrum_output
    import fft16_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  cplx_t [N_POINTS-1:0] result,
    input  logic                 result_ready,
    input  logic                 fir_valid,
    output logic                 fft_valid,
    output sample_t              fft_d0,
    output sample_t              fft_d1,
    output sample_t              fft_d2,
    output sample_t              fft_d3,
    output sample_t              fft_d4,
    output sample_t              fft_d5,
    output sample_t              fft_d6,
    output sample_t              fft_d7,
    output sample_t              fft_d8,
    output sample_t              fft_d9,
    output sample_t              fft_d10,
    output sample_t              fft_d11,
    output sample_t              fft_d12,
    output sample_t              fft_d13,
    output sample_t              fft_d14,
    output sample_t              fft_d15,
    output logic                 done
);

    spectrum_t              spec;
    sample_t [N_POINTS-1:0] lanes;
    logic                   beat_re;
    logic                   beat_im;
    logic                   show_im;
    logic                   fir_shadow;
    logic                   fft_shadow;
    logic                   in_end;
    logic                   out_end;
    logic                   wait_drain;

    function automatic logic [3:0] bit_rev4(input logic [3:0] x);
        return {x[0], x[1], x[2], x[3]};
    endfunction

    ////////////////////////////////////////////////////////////
    // capture in natural order, then real beat, imag beat
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            spec    <= '0;
            beat_re <= 1'b0;
            beat_im <= 1'b0;
            show_im <= 1'b0;
        end else begin
            beat_re <= result_ready;
            beat_im <= beat_re;
            if (result_ready) begin
                show_im <= 1'b0;
                for (int b = 0; b < N_POINTS; b++) begin
                    spec.re[b] <= result[bit_rev4(4'(b))].re[23:8];
                    spec.im[b] <= result[bit_rev4(4'(b))].im[23:8];
                end
            end else if (beat_re) begin
                show_im <= 1'b1;
            end
        end
    end

    assign fft_valid = beat_re | beat_im;
    assign lanes     = show_im ? spec.im : spec.re;

    assign fft_d0  = lanes[0];
    assign fft_d1  = lanes[1];
    assign fft_d2  = lanes[2];
    assign fft_d3  = lanes[3];
    assign fft_d4  = lanes[4];
    assign fft_d5  = lanes[5];
    assign fft_d6  = lanes[6];
    assign fft_d7  = lanes[7];
    assign fft_d8  = lanes[8];
    assign fft_d9  = lanes[9];
    assign fft_d10 = lanes[10];
    assign fft_d11 = lanes[11];
    assign fft_d12 = lanes[12];
    assign fft_d13 = lanes[13];
    assign fft_d14 = lanes[14];
    assign fft_d15 = lanes[15];

    ////////////////////////////////////////////////////////////
    // end of stream
    ////////////////////////////////////////////////////////////
    assign in_end  = fir_shadow & ~fir_valid;
    assign out_end = fft_shadow & ~fft_valid;

    // input ran dry, fire on the next spectrum that finishes leaving
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fir_shadow <= 1'b0;
            fft_shadow <= 1'b0;
            wait_drain <= 1'b0;
            done       <= 1'b0;
        end else begin
            fir_shadow <= fir_valid;
            fft_shadow <= fft_valid;
            if (in_end) begin
                wait_drain <= 1'b1;
            end
            if (wait_drain && out_end) begin
                done       <= 1'b1;
                wait_drain <= 1'b0;
            end else begin
                done <= 1'b0;
            end
        end
    end

endmodule

// File: src/fft16_top.sv
module fft16_top
    import fft16_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  sample_t fir_d,
    input  logic    fir_valid,
    output logic    fft_valid,
    output logic    done,
    output sample_t fft_d0,
    output sample_t fft_d1,
    output sample_t fft_d2,
    output sample_t fft_d3,
    output sample_t fft_d4,
    output sample_t fft_d5,
    output sample_t fft_d6,
    output sample_t fft_d7,
    output sample_t fft_d8,
    output sample_t fft_d9,
    output sample_t fft_d10,
    output sample_t fft_d11,
    output sample_t fft_d12,
    output sample_t fft_d13,
    output sample_t fft_d14,
    output sample_t fft_d15
);

    frame_t               frame;
    logic                 frame_ready;
    cplx_t [N_POINTS-1:0] result;
    logic                 result_ready;

    sample_collector u_collect (
        .clk         (clk),
        .rst         (rst),
        .fir_d       (fir_d),
        .fir_valid   (fir_valid),
        .frame       (frame),
        .frame_ready (frame_ready)
    );

    fft_stage_engine u_engine (
        .clk          (clk),
        .rst          (rst),
        .frame        (frame),
        .frame_ready  (frame_ready),
        .result       (result),
        .result_ready (result_ready)
    );

    spectrum_output u_out (
        .clk          (clk),
        .rst          (rst),
        .result       (result),
        .result_ready (result_ready),
        .fir_valid    (fir_valid),
        .fft_valid    (fft_valid),
        .fft_d0       (fft_d0),
        .fft_d1       (fft_d1),
        .fft_d2       (fft_d2),
        .fft_d3       (fft_d3),
        .fft_d4       (fft_d4),
        .fft_d5       (fft_d5),
        .fft_d6       (fft_d6),
        .fft_d7       (fft_d7),
        .fft_d8       (fft_d8),
        .fft_d9       (fft_d9),
        .fft_d10      (fft_d10),
        .fft_d11      (fft_d11),
        .fft_d12      (fft_d12),
        .fft_d13      (fft_d13),
        .fft_d14      (fft_d14),
        .fft_d15      (fft_d15),
        .done         (done)
    );

endmodule

// File: tb/fft16_chk.sv
module fft16_chk (
    input logic clk,
    input logic rst,
    input logic fft_valid,
    input logic done,
    input logic result_ready
);
    timeunit 1ns;
    timeprecision 1ns;

    int fails = 0;

    // spectrum leaves in exactly two beats
    valid_second_beat: assert property (@(posedge clk) disable iff (rst)
        $rose(fft_valid) |=> fft_valid)
        else begin
            $error("fft_valid dropped before the imaginary beat");
            fails++;
        end

    valid_two_beats: assert property (@(posedge clk) disable iff (rst)
        fft_valid && $past(fft_valid) |=> !fft_valid)
        else begin
            $error("fft_valid stayed high longer than two beats");
            fails++;
        end

    done_outside_valid: assert property (@(posedge clk) disable iff (rst)
        !(done && fft_valid))
        else begin
            $error("done asserted while fft_valid is high");
            fails++;
        end

    result_then_valid: assert property (@(posedge clk) disable iff (rst)
        result_ready |=> fft_valid)
        else begin
            $error("fft_valid missing in the cycle after result_ready");
            fails++;
        end

endmodule

bind fft16_top fft16_chk u_chk (
    .clk          (clk),
    .rst          (rst),
    .fft_valid    (fft_valid),
    .done         (done),
    .result_ready (result_ready)
);

// File: tb/fft16_tb.sv
module fft16_tb
    import fft16_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ns;

    typedef sample_t bins_t [N_POINTS];

    localparam int WAIT_LIMIT = 64;

    logic        clk = 1'b0;
    logic        rst;
    sample_t     fir_d;
    logic        fir_valid;
    logic        fft_valid;
    logic        done;
    sample_t     lane [N_POINTS];
    logic [31:0] rng = 32'd68;
    int          checks = 0;
    int          errors = 0;
    int          done_count = 0;

    always #20 clk = ~clk;

    // counted before the edge updates done
    always @(posedge clk) begin
        if (done) begin
            done_count <= done_count + 1;
        end
    end

    fft16_top uut (
        .clk       (clk),
        .rst       (rst),
        .fir_d     (fir_d),
        .fir_valid (fir_valid),
        .fft_valid (fft_valid),
        .done      (done),
        .fft_d0    (lane[0]),
        .fft_d1    (lane[1]),
        .fft_d2    (lane[2]),
        .fft_d3    (lane[3]),
        .fft_d4    (lane[4]),
        .fft_d5    (lane[5]),
        .fft_d6    (lane[6]),
        .fft_d7    (lane[7]),
        .fft_d8    (lane[8]),
        .fft_d9    (lane[9]),
        .fft_d10   (lane[10]),
        .fft_d11   (lane[11]),
        .fft_d12   (lane[12]),
        .fft_d13   (lane[13]),
        .fft_d14   (lane[14]),
        .fft_d15   (lane[15])
    );

    ////////////////////////////////////////////////////////////
    // helpers and reference model
    ////////////////////////////////////////////////////////////
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [3:0] reverse_bits4(input logic [3:0] x);
        logic [3:0] r;
        for (int i = 0; i < 4; i++) begin
            r[i] = x[3 - i];
        end
        return r;
    endfunction

    // Q16 product, keep bits 47:16
    function automatic word_t q16_mul(input word_t x, input word_t w, input bit negate);
        logic signed [63:0] xe;
        logic signed [63:0] we;
        logic signed [63:0] p;
        xe = 64'(x);
        we = 64'(w);
        if (negate) begin
            xe = -xe;
        end
        p = xe * we;
        return p[47:16];
    endfunction

    task automatic model_fft(input bins_t s, output bins_t exp_re, output bins_t exp_im);
        word_t re [N_POINTS];
        word_t im [N_POINTS];
        word_t d_re;
        word_t d_im;
        int    ia;
        int    ib;
        int    it;
        for (int i = 0; i < N_POINTS; i++) begin
            re[i] = word_t'(s[i]) <<< 8;
            im[i] = '0;
        end
        for (int st = 1; st <= N_STAGES; st++) begin
            for (int k = 0; k < N_BFLY; k++) begin
                ia = int'(stage_pair_a(3'(st), 3'(k)));
                ib = int'(stage_pair_b(3'(st), 3'(k)));
                it = int'(stage_twiddle(3'(st), 3'(k)));
                d_re = re[ia] - re[ib];
                d_im = im[ia] - im[ib];
                re[ia] = re[ia] + re[ib];
                im[ia] = im[ia] + im[ib];
                re[ib] = q16_mul(d_re, TW_RE[it], 1'b0) + q16_mul(d_im, TW_IM[it], 1'b1);
                im[ib] = q16_mul(d_re, TW_IM[it], 1'b0) + q16_mul(d_im, TW_RE[it], 1'b0);
            end
        end
        // DIF leaves bin b at the bit reversed slot
        for (int b = 0; b < N_POINTS; b++) begin
            exp_re[b] = re[reverse_bits4(4'(b))][23:8];
            exp_im[b] = im[reverse_bits4(4'(b))][23:8];
        end
    endtask

    task automatic expect_equal(input string name, input sample_t got, input sample_t exp);
        checks++;
        assert (got == exp) else begin
            $display("[FAIL] t=%0t %s: got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic expect_low(input string name, input logic v);
        checks++;
        assert (v == 1'b0) else begin
            $display("[FAIL] t=%0t %s: got %0b expected 0", $time, name, v);
            errors++;
        end
    endtask

    task automatic outputs_idle(input string when);
        expect_low($sformatf("fft_valid (%s)", when), fft_valid);
        expect_low($sformatf("done (%s)", when), done);
        for (int i = 0; i < N_POINTS; i++) begin
            expect_equal($sformatf("fft_d%0d (%s)", i, when), lane[i], 16'sd0);
        end
    endtask

    task automatic send_frame(input bins_t s, input bit stop_after);
        for (int i = 0; i < N_POINTS; i++) begin
            @(posedge clk);
            fir_d     <= s[i];
            fir_valid <= 1'b1;
        end
        if (stop_after) begin
            @(posedge clk);
            fir_d     <= '0;
            fir_valid <= 1'b0;
        end
    endtask

    // real beat then imaginary beat, sampled on the falling edge
    task automatic wait_spectrum(input string tag, output bins_t re, output bins_t im);
        int n;
        n = 0;
        @(negedge clk);
        while (!fft_valid && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        checks++;
        assert (fft_valid) else begin
            $display("%s: no spectrum appeared within %0d cycles", tag, WAIT_LIMIT);
            errors++;
        end
        re = lane;
        @(negedge clk);
        checks++;
        assert (fft_valid) else begin
            $display("%s: fft_valid fell before the imaginary beat", tag);
            errors++;
        end
        im = lane;
    endtask

    task automatic compare_bins(input string tag, input bins_t got_re, input bins_t got_im,
                                input bins_t exp_re, input bins_t exp_im);
        for (int b = 0; b < N_POINTS; b++) begin
            expect_equal($sformatf("fft_d%0d real (%s)", b, tag), got_re[b], exp_re[b]);
            expect_equal($sformatf("fft_d%0d imag (%s)", b, tag), got_im[b], exp_im[b]);
        end
    endtask

    task automatic random_frame(output bins_t s);
        for (int i = 0; i < N_POINTS; i++) begin
            rng  = xorshift32(rng);
            s[i] = sample_t'(rng[31:16]);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////
    task automatic reset_state();
        int err0;
        err0 = errors;
        @(negedge clk);
        outputs_idle("during reset");
        @(posedge clk);
        rst <= 1'b0;
        repeat (3) begin
            @(negedge clk);
            outputs_idle("after reset");
        end
        $display("reset_state finished, %0d errors", errors - err0);
    endtask

    task automatic impulse_response();
        bins_t   s;
        bins_t   got_re;
        bins_t   got_im;
        bins_t   exp_re;
        bins_t   exp_im;
        sample_t a;
        int      err0;
        err0 = errors;
        a    = 16'sh1234;
        for (int i = 0; i < N_POINTS; i++) begin
            s[i]      = (i == 0) ? a : 16'sd0;
            exp_re[i] = a;
            exp_im[i] = 16'sd0;
        end
        send_frame(s, 1'b1);
        wait_spectrum("impulse", got_re, got_im);
        compare_bins("impulse", got_re, got_im, exp_re, exp_im);
        repeat (4) @(negedge clk);
        $display("impulse_response finished, %0d errors", errors - err0);
    endtask

    task automatic dc_response();
        bins_t   s;
        bins_t   got_re;
        bins_t   got_im;
        bins_t   exp_re;
        bins_t   exp_im;
        sample_t c;
        int      err0;
        err0 = errors;
        // 16 * c wraps in the output lane
        c = -16'sd2500;
        for (int i = 0; i < N_POINTS; i++) begin
            s[i]      = c;
            exp_re[i] = 16'sd0;
            exp_im[i] = 16'sd0;
        end
        exp_re[0] = sample_t'(int'(c) * 16);
        send_frame(s, 1'b1);
        wait_spectrum("dc", got_re, got_im);
        compare_bins("dc", got_re, got_im, exp_re, exp_im);
        repeat (4) @(negedge clk);
        $display("dc_response finished, %0d errors", errors - err0);
    endtask

    task automatic random_frames();
        bins_t s;
        bins_t got_re;
        bins_t got_im;
        bins_t exp_re;
        bins_t exp_im;
        int    err0;
        err0 = errors;
        for (int f = 0; f < 4; f++) begin
            random_frame(s);
            model_fft(s, exp_re, exp_im);
            send_frame(s, 1'b1);
            wait_spectrum($sformatf("random %0d", f), got_re, got_im);
            compare_bins($sformatf("random %0d", f), got_re, got_im, exp_re, exp_im);
            repeat (4) @(negedge clk);
        end
        $display("random_frames finished, %0d errors", errors - err0);
    endtask

    task automatic streaming_frames();
        bins_t frames [3];
        bins_t exp_re [3];
        bins_t exp_im [3];
        bins_t got_re;
        bins_t got_im;
        int    done_start;
        int    n;
        int    err0;
        err0       = errors;
        done_start = done_count;
        for (int f = 0; f < 3; f++) begin
            random_frame(frames[f]);
            model_fft(frames[f], exp_re[f], exp_im[f]);
        end
        fork
            begin
                for (int f = 0; f < 3; f++) begin
                    send_frame(frames[f], f == 2);
                end
            end
            begin
                for (int f = 0; f < 3; f++) begin
                    wait_spectrum($sformatf("stream %0d", f), got_re, got_im);
                    compare_bins($sformatf("stream %0d", f), got_re, got_im,
                                 exp_re[f], exp_im[f]);
                end
            end
        join
        // nothing may fire before the last imaginary beat
        checks++;
        assert (done_count == done_start && !done) else begin
            $display("done pulsed before the last spectrum had left");
            errors++;
        end
        n = 0;
        @(negedge clk);
        while (!done && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        checks++;
        assert (done) else begin
            $display("done never pulsed after the end of the stream");
            errors++;
        end
        repeat (6) @(negedge clk);
        checks++;
        assert (done_count == done_start + 1) else begin
            $display("expected one done pulse, saw %0d", done_count - done_start);
            errors++;
        end
        $display("streaming_frames finished, %0d errors", errors - err0);
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////
    initial begin
        rst       = 1'b1;
        fir_d     = '0;
        fir_valid = 1'b0;
        reset_state();
        impulse_response();
        dc_response();
        random_frames();
        streaming_frames();
        errors += uut.u_chk.fails;
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: flist.f
src/fft16_pkg.sv
src/sample_collector.sv
src/butterfly.sv
src/fft_stage_engine.sv
src/spectrum_output.sv
src/fft16_top.sv
tb/fft16_chk.sv
tb/fft16_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the FFT testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f flist.f --top-module fft16_tb -Mdir obj_dir \
    && ./obj_dir/Vfft16_tb | tee sim.log \
    || { echo "build or simulation failed"; exit 1; }
grep -q "TEST PASSED" sim.log && exit 0 || exit 1
